// File: include/periph_consts.svh
/*
 * Peripheral subsystem constants
 * Bus widths, pad count, slave bases and register offsets
 */

`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Bus widths
`define W_PADDR       16
`define W_DATA        32

`define N_PADS        11   // GPIO pads on the package

// Slave bases, decoded on paddr[15:12]
`define GPIO_BASE     16'h0000
`define PWM_BASE      16'h1000

// GPIO register offsets, decoded on the low address byte
`define GPIO_REG_OUT  8'h00
`define GPIO_REG_OE   8'h04
`define GPIO_REG_IN   8'h08
`define GPIO_REG_SET  8'h0C
`define GPIO_REG_CLR  8'h10

// PWM register offsets
`define PWM_REG_CTRL  8'h00
`define PWM_REG_COUNT 8'h04

`define PWM_COUNT_W   8    // Duty counter width

`endif

// File: src/periph_pkg.sv
/*
 * Peripheral package
 * Control word layout of the PWM block
 */

`default_nettype none

`include "periph_consts.svh"

package periph_pkg;

	// Field view of the PWM control register
	typedef struct packed {
		logic                    en;    // Bit 31, run the counter
		logic                    inv;   // Bit 30, invert the output
		logic [13:0]             rsvd;
		logic [7:0]              div;   // Counter steps every div+1 clocks
		logic [`PWM_COUNT_W-1:0] duty;  // High while count < duty
	} pwm_ctrl_fields_t;

	// Bus side sees the raw word, counter logic reads the fields
	typedef union packed {
		logic [`W_DATA-1:0] raw;
		pwm_ctrl_fields_t   f;
	} pwm_ctrl_t;

endpackage

`default_nettype wire

// File: src/apb_if.sv
/*
 * APB bus bundle between the address splitter and one slave
 */

`default_nettype none

`include "periph_consts.svh"

interface apb_if;

	logic [`W_PADDR-1:0] paddr;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [`W_DATA-1:0]  pwdata;
	logic [`W_DATA-1:0]  prdata;
	logic                pready;
	logic                pslverr;

	modport master (output paddr, psel, penable, pwrite, pwdata,
		input prdata, pready, pslverr);

	modport slave (input paddr, psel, penable, pwrite, pwdata,
		output prdata, pready, pslverr);

endinterface

`default_nettype wire

// File: src/apb_splitter.sv
/*
 * APB address splitter
 * Routes each transfer to GPIO or PWM by the top address nibble,
 * unmapped addresses get an error response
 */

`default_nettype none

`include "periph_consts.svh"

module apb_splitter (
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [`W_PADDR-1:0] paddr,
	input  logic [`W_DATA-1:0]  pwdata,
	output logic [`W_DATA-1:0]  prdata,
	output logic                pready,
	output logic                pslverr,

	apb_if.master               gpio_bus,
	apb_if.master               pwm_bus
);

localparam logic [`W_PADDR-1:0] gpio_base = `GPIO_BASE;
localparam logic [`W_PADDR-1:0] pwm_base  = `PWM_BASE;

logic hit_gpio;
logic hit_pwm;

// =========================================================================
//  Address decode
// =========================================================================

assign hit_gpio = paddr[`W_PADDR-1 -: 4] == gpio_base[`W_PADDR-1 -: 4];
assign hit_pwm  = paddr[`W_PADDR-1 -: 4] == pwm_base[`W_PADDR-1 -: 4];

// =========================================================================
//  Request fan-out
// =========================================================================

// Only the selected slave sees psel, the rest is broadcast
assign gpio_bus.psel    = psel && hit_gpio;
assign gpio_bus.penable = penable;
assign gpio_bus.pwrite  = pwrite;
assign gpio_bus.paddr   = paddr;
assign gpio_bus.pwdata  = pwdata;

assign pwm_bus.psel     = psel && hit_pwm;
assign pwm_bus.penable  = penable;
assign pwm_bus.pwrite   = pwrite;
assign pwm_bus.paddr    = paddr;
assign pwm_bus.pwdata   = pwdata;

// =========================================================================
//  Response mux
// =========================================================================

always_comb begin
	prdata  = '0;                       // Also the unmapped read value
	pslverr = 1'b0;
	pready  = 1'b1;                     // Unmapped completes at once
	if (hit_gpio) begin
		pready = gpio_bus.pready;
		if (psel) begin
			prdata  = gpio_bus.prdata;
			pslverr = gpio_bus.pslverr;
		end
	end else if (hit_pwm) begin
		pready = pwm_bus.pready;
		if (psel) begin
			prdata  = pwm_bus.prdata;
			pslverr = pwm_bus.pslverr;
		end
	end else begin
		pslverr = psel && penable;      // Error only in the access cycle
	end
end

endmodule

`default_nettype wire

// File: src/gpio_regs.sv
/*
 * GPIO register block
 * Output and output-enable registers with set/clear aliases,
 * pad inputs sampled through a two-flop synchronizer
 */

`default_nettype none

`include "periph_consts.svh"

module gpio_regs (
	input  logic               clk_sys,
	input  logic               rst,

	apb_if.slave               bus,

	output logic [`N_PADS-1:0] padout,
	output logic [`N_PADS-1:0] padoe,
	input  logic [`N_PADS-1:0] padin
);

logic               wen;
logic [7:0]         reg_addr;
logic [`N_PADS-1:0] wbits;
logic [`N_PADS-1:0] in_meta;
logic [`N_PADS-1:0] in_sync;

assign reg_addr = bus.paddr[7:0];
assign wbits    = bus.pwdata[`N_PADS-1:0];
assign wen      = bus.psel && bus.penable && bus.pwrite;

// =========================================================================
//  Output registers
// =========================================================================

always_ff @(posedge clk_sys) begin
	if (rst) begin
		padout <= '0;
		padoe  <= '0;
	end else if (wen) begin
		case (reg_addr)
			`GPIO_REG_OUT: padout <= wbits;
			`GPIO_REG_OE:  padoe  <= wbits;
			`GPIO_REG_SET: padout <= padout | wbits;
			`GPIO_REG_CLR: padout <= padout & ~wbits;
			default: ;                      // IN and holes ignore writes
		endcase
	end
end

// Pad inputs are asynchronous to clk_sys
always_ff @(posedge clk_sys) begin
	in_meta <= padin;
	in_sync <= in_meta;
end

// =========================================================================
//  Read side
// =========================================================================

always_comb begin
	bus.prdata = '0;
	case (reg_addr)
		`GPIO_REG_OUT: bus.prdata[`N_PADS-1:0] = padout;
		`GPIO_REG_OE:  bus.prdata[`N_PADS-1:0] = padoe;
		`GPIO_REG_IN:  bus.prdata[`N_PADS-1:0] = in_sync;
		default:       bus.prdata = '0;    // SET and CLR are write-only
	endcase
end

assign bus.pready  = 1'b1;     // Zero wait states
assign bus.pslverr = 1'b0;

endmodule

`default_nettype wire

// File: src/pwm_tiny.sv
/*
 * Small PWM block
 * Prescaled 8-bit counter compared against a duty value,
 * with a control register and counter readback on APB
 */

`default_nettype none

`include "periph_consts.svh"

module pwm_tiny import periph_pkg::*; (
	input  logic clk_sys,
	input  logic rst,

	apb_if.slave bus,

	output logic pwm_out
);

pwm_ctrl_t               ctrl;
logic [7:0]              presc;
logic [`PWM_COUNT_W-1:0] count;
logic                    wen;
logic                    step;

assign wen  = bus.psel && bus.penable && bus.pwrite;
assign step = presc >= ctrl.f.div;      // Also recovers if div shrinks mid-count

// =========================================================================
//  Control register
// =========================================================================

always_ff @(posedge clk_sys) begin
	if (rst) begin
		ctrl.raw <= '0;
	end else if (wen && bus.paddr[7:0] == `PWM_REG_CTRL) begin
		ctrl.raw <= bus.pwdata;
	end
end

// =========================================================================
//  Prescaler, counter and output
// =========================================================================

always_ff @(posedge clk_sys) begin
	if (rst) begin
		presc   <= '0;
		count   <= '0;
		pwm_out <= 1'b0;
	end else if (!ctrl.f.en) begin
		presc   <= '0;
		count   <= '0;
		pwm_out <= ctrl.f.inv;              // Idle level
	end else begin
		if (step) begin
			presc <= '0;
			count <= count + 1'b1;          // Wraps at 256
		end else begin
			presc <= presc + 1'b1;
		end
		pwm_out <= (count < ctrl.f.duty) ^ ctrl.f.inv;
	end
end

// Readback
always_comb begin
	case (bus.paddr[7:0])
		`PWM_REG_CTRL:  bus.prdata = ctrl.raw;
		`PWM_REG_COUNT: begin
			bus.prdata = '0;
			bus.prdata[`PWM_COUNT_W-1:0] = count;
		end
		default:        bus.prdata = '0;
	endcase
end

assign bus.pready  = 1'b1;
assign bus.pslverr = 1'b0;

endmodule

`default_nettype wire

// File: src/gpio_pwm_subsys.sv
/*
 * GPIO and PWM peripheral subsystem
 * One external APB slave port split between the GPIO and PWM blocks
 */

`default_nettype none

`include "periph_consts.svh"

module gpio_pwm_subsys (
	input  wire                clk_sys,
	input  wire                rst,

	// APB slave port
	input  wire                psel,
	input  wire                penable,
	input  wire                pwrite,
	input  wire [`W_PADDR-1:0] paddr,
	input  wire [`W_DATA-1:0]  pwdata,
	output wire [`W_DATA-1:0]  prdata,
	output wire                pready,
	output wire                pslverr,

	// Pads
	output wire [`N_PADS-1:0]  padout,
	output wire [`N_PADS-1:0]  padoe,
	input  wire [`N_PADS-1:0]  padin,

	output wire                pwm_out   // Backlight line
);

// =========================================================================
//  Bus fabric
// =========================================================================

apb_if gpio_bus ();
apb_if pwm_bus ();

apb_splitter inst_apb_splitter (
	.psel     (psel),
	.penable  (penable),
	.pwrite   (pwrite),
	.paddr    (paddr),
	.pwdata   (pwdata),
	.prdata   (prdata),
	.pready   (pready),
	.pslverr  (pslverr),
	.gpio_bus (gpio_bus.master),
	.pwm_bus  (pwm_bus.master)
);

// =========================================================================
//  Slaves
// =========================================================================

gpio_regs inst_gpio_regs (
	.clk_sys (clk_sys),
	.rst     (rst),
	.bus     (gpio_bus.slave),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin)
);

pwm_tiny inst_pwm_tiny (
	.clk_sys (clk_sys),
	.rst     (rst),
	.bus     (pwm_bus.slave),
	.pwm_out (pwm_out)
);

endmodule

`default_nettype wire

// File: testbench/gpio_pwm_subsys_props.sv
/*
 * Bound checks on the subsystem ports
 * APB handshake, error response, reset levels and PWM idle level
 */

`default_nettype none

`include "periph_consts.svh"

module gpio_pwm_subsys_props (
	input logic                clk_sys,
	input logic                rst,
	input logic                psel,
	input logic                penable,
	input logic                pwrite,
	input logic [`W_PADDR-1:0] paddr,
	input logic [`W_DATA-1:0]  pwdata,
	input logic                pslverr,
	input logic [`N_PADS-1:0]  padoe,
	input logic                pwm_out
);

localparam logic [`W_PADDR-1:0] gpio_base = `GPIO_BASE;
localparam logic [`W_PADDR-1:0] pwm_base  = `PWM_BASE;

logic unmapped;
logic ctrl_wr;
logic sh_en;    // Shadow of the PWM control bits, taken from bus writes
logic sh_inv;

assign unmapped = paddr[`W_PADDR-1 -: 4] != gpio_base[`W_PADDR-1 -: 4]
	&& paddr[`W_PADDR-1 -: 4] != pwm_base[`W_PADDR-1 -: 4];
assign ctrl_wr  = psel && penable && pwrite
	&& paddr[`W_PADDR-1 -: 4] == pwm_base[`W_PADDR-1 -: 4]
	&& paddr[7:0] == `PWM_REG_CTRL;

always_ff @(posedge clk_sys) begin
	if (rst) begin
		sh_en  <= 1'b0;
		sh_inv <= 1'b0;
	end else if (ctrl_wr) begin
		sh_en  <= pwdata[31];
		sh_inv <= pwdata[30];
	end
end

// =========================================================================
//  Properties
// =========================================================================

a_penable_psel: assert property (@(posedge clk_sys) disable iff (rst)
	penable |-> psel)
	else $error("penable high without psel");

a_slverr_unmapped: assert property (@(posedge clk_sys) disable iff (rst)
	pslverr |-> (psel && penable && unmapped))
	else $error("pslverr outside an unmapped access cycle");

a_reset_levels: assert property (@(posedge clk_sys)
	rst |=> (padoe == '0 && pwm_out == 1'b0))
	else $error("padoe or pwm_out not zero after reset");

// Output register follows inv one edge later
a_idle_level: assert property (@(posedge clk_sys) disable iff (rst)
	!sh_en |=> (pwm_out == $past(sh_inv)))
	else $error("pwm_out differs from inv while disabled");

endmodule

bind gpio_pwm_subsys gpio_pwm_subsys_props props0 (
	.clk_sys (clk_sys),
	.rst     (rst),
	.psel    (psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.pslverr (pslverr),
	.padoe   (padoe),
	.pwm_out (pwm_out)
);

`default_nettype wire

// File: testbench/tb_gpio_pwm_subsys.sv
/*
 * Testbench for the GPIO and PWM subsystem
 * APB transfers against reference models of the GPIO registers and PWM duty
 */

`default_nettype none

`include "periph_consts.svh"

module tb_gpio_pwm_subsys import periph_pkg::*; ();

localparam int half_period = 10;
localparam int cycle_limit = 20000;          // Tests need about 6000 cycles
localparam logic [`W_PADDR-1:0] bad_base = 16'h3000;

logic                clk_sys;
logic                rst;
logic                psel;
logic                penable;
logic                pwrite;
logic [`W_PADDR-1:0] paddr;
logic [`W_DATA-1:0]  pwdata;
logic [`W_DATA-1:0]  prdata;
logic                pready;
logic                pslverr;
logic [`N_PADS-1:0]  padout;
logic [`N_PADS-1:0]  padoe;
logic [`N_PADS-1:0]  padin;
logic                pwm_out;

integer               seed;
int                   n_checks;
int                   n_errors;
int                   cycle_count;
logic [2*`N_PADS-1:0] gpio_state;     // Model of {OE, OUT}

gpio_pwm_subsys dut0 (
	.clk_sys (clk_sys),
	.rst     (rst),
	.psel    (psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.pwdata  (pwdata),
	.prdata  (prdata),
	.pready  (pready),
	.pslverr (pslverr),
	.padout  (padout),
	.padoe   (padoe),
	.padin   (padin),
	.pwm_out (pwm_out)
);

initial begin
	clk_sys = 1'b0;
	forever #(half_period) clk_sys = ~clk_sys;
end

// =========================================================================
//  Reference models
// =========================================================================

function automatic logic [2*`N_PADS-1:0] gpio_model(input logic [7:0] offset,
		input logic [`W_DATA-1:0] data, input logic [2*`N_PADS-1:0] state);
	logic [`N_PADS-1:0] m_out;
	logic [`N_PADS-1:0] m_oe;
	logic [`N_PADS-1:0] bits;
	m_oe  = state[2*`N_PADS-1:`N_PADS];
	m_out = state[`N_PADS-1:0];
	bits  = data[`N_PADS-1:0];
	if (offset == `GPIO_REG_OUT) m_out = bits;
	else if (offset == `GPIO_REG_OE) m_oe = bits;
	else if (offset == `GPIO_REG_SET) m_out = m_out | bits;
	else if (offset == `GPIO_REG_CLR) m_out = m_out & ~bits;
	return {m_oe, m_out};
endfunction

// High cycles over one full counter period
function automatic int pwm_high_count(input logic [7:0] duty, input logic [7:0] div,
		input logic inv);
	int high_steps;
	if (inv) high_steps = 256 - int'(duty);
	else high_steps = int'(duty);
	return high_steps * (int'(div) + 1);
endfunction

function automatic logic [`W_PADDR-1:0] gpio_addr(input logic [7:0] offset);
	return `GPIO_BASE | {8'h00, offset};
endfunction

function automatic logic [`W_PADDR-1:0] pwm_addr(input logic [7:0] offset);
	return `PWM_BASE | {8'h00, offset};
endfunction

// =========================================================================
//  APB tasks and checks
// =========================================================================

task automatic apb_transfer(input logic wr, input logic [`W_PADDR-1:0] addr,
		input logic [`W_DATA-1:0] wdata, output logic [`W_DATA-1:0] rdata, output logic err);
	@(negedge clk_sys);
	psel    = 1'b1;                  // Setup cycle
	penable = 1'b0;
	pwrite  = wr;
	paddr   = addr;
	pwdata  = wdata;
	@(negedge clk_sys);
	penable = 1'b1;                  // Access cycle
	#(half_period / 2);
	check_value("pready", 32'h1, 32'(pready));   // Both slaves are zero-wait
	while (!pready) begin
		@(negedge clk_sys);
		#(half_period / 2);
	end
	rdata = prdata;
	err   = pslverr;
	@(negedge clk_sys);              // Ending edge has passed
	psel    = 1'b0;
	penable = 1'b0;
	pwrite  = 1'b0;
endtask

task automatic apb_write(input logic [`W_PADDR-1:0] addr, input logic [`W_DATA-1:0] data,
		output logic err);
	logic [`W_DATA-1:0] ignored;
	apb_transfer(1'b1, addr, data, ignored, err);
endtask

task automatic apb_read(input logic [`W_PADDR-1:0] addr, output logic [`W_DATA-1:0] data,
		output logic err);
	apb_transfer(1'b0, addr, 32'h0, data, err);
endtask

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	n_checks++;
	if (actual !== expected) begin
		$display("[FAIL] t=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
		n_errors++;
	end
endtask

task automatic read_check(input logic [`W_PADDR-1:0] addr, input logic [`W_DATA-1:0] expected,
		input string name);
	logic [`W_DATA-1:0] rd;
	logic               err;
	apb_read(addr, rd, err);
	check_value(name, expected, rd);
	check_value("pslverr", 32'h0, 32'(err));
endtask

task automatic write_check(input logic [`W_PADDR-1:0] addr, input logic [`W_DATA-1:0] data);
	logic err;
	apb_write(addr, data, err);
	check_value("pslverr", 32'h0, 32'(err));
endtask

// Write one GPIO register, then compare the pads with the model
task automatic gpio_write_check(input logic [7:0] offset, input logic [`W_DATA-1:0] data);
	write_check(gpio_addr(offset), data);
	gpio_state = gpio_model(offset, data, gpio_state);
	check_value("padout", 32'(gpio_state[`N_PADS-1:0]), 32'(padout));
	check_value("padoe", 32'(gpio_state[2*`N_PADS-1:`N_PADS]), 32'(padoe));
endtask

task automatic report_test(input string name, input int errs_before);
	if (n_errors == errs_before) $display("test %s: ok", name);
	else $display("test %s: %0d errors", name, n_errors - errs_before);
endtask

// =========================================================================
//  Tests
// =========================================================================

task automatic test_reset();
	int errs;
	errs = n_errors;
	check_value("padout", 32'h0, 32'(padout));
	check_value("padoe", 32'h0, 32'(padoe));
	check_value("pwm_out", 32'h0, 32'(pwm_out));
	read_check(gpio_addr(`GPIO_REG_OUT), 32'h0, "OUT");
	read_check(gpio_addr(`GPIO_REG_OE), 32'h0, "OE");
	read_check(pwm_addr(`PWM_REG_CTRL), 32'h0, "CTRL");
	read_check(pwm_addr(`PWM_REG_COUNT), 32'h0, "COUNT");
	report_test("reset", errs);
endtask

task automatic test_gpio_regs();
	int errs;
	errs = n_errors;
	repeat (6) begin
		gpio_write_check(`GPIO_REG_OUT, $random(seed));
		gpio_write_check(`GPIO_REG_OE, $random(seed));
		read_check(gpio_addr(`GPIO_REG_OUT), 32'(gpio_state[`N_PADS-1:0]), "OUT");
		read_check(gpio_addr(`GPIO_REG_OE), 32'(gpio_state[2*`N_PADS-1:`N_PADS]), "OE");
	end
	repeat (6) begin
		gpio_write_check(`GPIO_REG_SET, $random(seed));
		gpio_write_check(`GPIO_REG_CLR, $random(seed));
		read_check(gpio_addr(`GPIO_REG_OUT), 32'(gpio_state[`N_PADS-1:0]), "OUT");
	end
	report_test("gpio registers", errs);
endtask

task automatic test_gpio_input();
	int          errs;
	logic [31:0] r;
	errs = n_errors;
	repeat (4) begin
		r = $random(seed);
		@(negedge clk_sys);
		padin = r[`N_PADS-1:0];
		repeat (3) @(negedge clk_sys);      // Past the synchronizer
		read_check(gpio_addr(`GPIO_REG_IN), 32'(r[`N_PADS-1:0]), "IN");
	end
	report_test("gpio input", errs);
endtask

task automatic run_pwm(input logic [7:0] duty, input logic [7:0] div, input logic inv);
	pwm_ctrl_t ctrl;
	int        high_cnt;
	int        window;
	ctrl.raw    = '0;
	ctrl.f.en   = 1'b1;
	ctrl.f.inv  = inv;
	ctrl.f.div  = div;
	ctrl.f.duty = duty;
	write_check(pwm_addr(`PWM_REG_CTRL), ctrl.raw);
	read_check(pwm_addr(`PWM_REG_CTRL), ctrl.raw, "CTRL");
	repeat (512) @(negedge clk_sys);
	high_cnt = 0;
	window   = 256 * (int'(div) + 1);       // One full counter period
	repeat (window) begin
		@(negedge clk_sys);
		if (pwm_out) high_cnt++;
	end
	check_value("pwm_out high cycles", pwm_high_count(duty, div, inv), high_cnt);
	write_check(pwm_addr(`PWM_REG_CTRL), 32'h0);
endtask

task automatic test_pwm();
	int errs;
	errs = n_errors;
	run_pwm(8'd64, 8'd0, 1'b0);
	run_pwm(8'd200, 8'd1, 1'b0);
	run_pwm(8'd17, 8'd3, 1'b0);
	run_pwm(8'd128, 8'd2, 1'b0);
	run_pwm(8'd64, 8'd1, 1'b1);
	report_test("pwm duty", errs);
endtask

task automatic test_decode();
	int                 errs;
	logic [`W_DATA-1:0] rd;
	logic               err;
	errs = n_errors;
	write_check(pwm_addr(`PWM_REG_CTRL), 32'h0000_0521);   // Disabled, div 5, duty 0x21
	apb_write(bad_base, $random(seed), err);
	check_value("pslverr", 32'h1, 32'(err));
	apb_read(bad_base, rd, err);
	check_value("pslverr", 32'h1, 32'(err));
	check_value("prdata", 32'h0, rd);
	check_value("padout", 32'(gpio_state[`N_PADS-1:0]), 32'(padout));
	check_value("padoe", 32'(gpio_state[2*`N_PADS-1:`N_PADS]), 32'(padoe));
	read_check(gpio_addr(`GPIO_REG_OUT), 32'(gpio_state[`N_PADS-1:0]), "OUT");
	read_check(gpio_addr(`GPIO_REG_OE), 32'(gpio_state[2*`N_PADS-1:`N_PADS]), "OE");
	read_check(pwm_addr(`PWM_REG_CTRL), 32'h0000_0521, "CTRL");
	write_check(pwm_addr(`PWM_REG_CTRL), 32'h0);
	report_test("address decode", errs);
endtask

// =========================================================================
//  Run control
// =========================================================================

initial begin
	cycle_count = 0;
	while (cycle_count < cycle_limit) begin
		@(posedge clk_sys);
		cycle_count++;
	end
	$display("Timeout after %0d cycles, the DUT or a test hung", cycle_count);
	$display("SIMULATION FAILED");
	$finish;
end

initial begin
	seed       = 32'hea53_84fc;
	n_checks   = 0;
	n_errors   = 0;
	gpio_state = '0;
	rst        = 1'b1;
	psel       = 1'b0;
	penable    = 1'b0;
	pwrite     = 1'b0;
	paddr      = '0;
	pwdata     = '0;
	padin      = '0;
	repeat (8) @(negedge clk_sys);
	rst = 1'b0;

	test_reset();
	test_gpio_regs();
	test_gpio_input();
	test_pwm();
	test_decode();

	$display("checks %0d, errors %0d", n_checks, n_errors);
	if (n_errors == 0) begin
		$display("SIMULATION PASSED");
	end else begin
		$display("SIMULATION FAILED");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: gpio_pwm_subsys.f
+incdir+include
src/periph_pkg.sv
src/apb_if.sv
src/apb_splitter.sv
src/gpio_regs.sv
src/pwm_tiny.sv
src/gpio_pwm_subsys.sv
testbench/gpio_pwm_subsys_props.sv
testbench/tb_gpio_pwm_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f gpio_pwm_subsys.f \
	--top-module tb_gpio_pwm_subsys \
	-o tb_gpio_pwm_subsys \
	&& ./obj_dir/tb_gpio_pwm_subsys > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
